/* logic/decodeStage.sv */
`timescale 1ns/100ps

module decodeStage (
	input logic clk,
	input logic rst_i,
	input logic flushE_i,
	input logic stallD_i,
	fetchDecIfc.dst fetchDec,
	wbIfc.dst wb,
	decExIfc.src decEx,
	output pipePkg::regAddr_t rsD_o,
	output pipePkg::regAddr_t rtD_o
);
	import pipePkg::*;

	word_t regs [32];
	opcode_e opcode;
	funct_e funct;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	ctrl_t ctrl;
	logic knownOp;
	word_t imm;
	word_t pcPlus4;
	logic wbWrite;

	// Register 0 reads as zero, and a same-cycle write from writeback bypasses the array.
	function automatic word_t readReg(regAddr_t r);
		if (r == '0) begin
			return '0;
		end else if (wbWrite && wb.destReg == r) begin
			return wb.wbData;
		end
		return regs[r];
	endfunction

	assign opcode = opcode_e'(fetchDec.instr[31:26]);
	assign funct = funct_e'(fetchDec.instr[5:0]);
	assign rs = fetchDec.instr[25:21];
	assign rt = fetchDec.instr[20:16];
	assign rd = fetchDec.instr[15:11];
	assign rsD_o = rs;
	assign rtD_o = rt;
	assign pcPlus4 = fetchDec.pc + 32'd4;
	assign wbWrite = wb.valid && wb.regWrite && wb.destReg != '0;

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluPassB;
		knownOp = 1'b1;
		case (opcode)
			rType: begin
				ctrl.regWrite = 1'b1;
				case (funct)
					addu: ctrl.aluOp = aluAdd;
					subu: ctrl.aluOp = aluSub;
					andOp: ctrl.aluOp = aluAnd;
					orOp: ctrl.aluOp = aluOr;
					slt: ctrl.aluOp = aluSlt;
					// Anything else, such as the all-zero nop, retires without effect.
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			addiu: begin
				ctrl.aluOp = aluAdd;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			ori: begin
				ctrl.aluOp = aluOr;
				ctrl.useImm = 1'b1;
				ctrl.zeroExtend = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			lw: begin
				ctrl.aluOp = aluAdd;
				ctrl.useImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end
			sw: begin
				ctrl.aluOp = aluAdd;
				ctrl.useImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			beq: ctrl.isBranch = 1'b1;
			j: ctrl.isJump = 1'b1;
			default: knownOp = 1'b0;
		endcase
	end

	assign imm = ctrl.zeroExtend ? {16'b0, fetchDec.instr[15:0]}
		: {{16{fetchDec.instr[15]}}, fetchDec.instr[15:0]};

	always_ff @(posedge clk) begin
		if (wbWrite) begin
			regs[wb.destReg] <= wb.wbData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			decEx.valid <= 1'b0;
		end else begin
			decEx.valid <= fetchDec.valid && !flushE_i && !stallD_i;
		end
	end

	always_ff @(posedge clk) begin
		decEx.pc <= fetchDec.pc;
		decEx.ctrl <= ctrl;
		decEx.rsVal <= readReg(rs);
		decEx.rtVal <= readReg(rt);
		decEx.imm <= imm;
		decEx.rs <= rs;
		decEx.rt <= rt;
		decEx.destReg <= (opcode == rType) ? rd : rt;
		decEx.jumpTarget <= {pcPlus4[31:28], fetchDec.instr[25:0], 2'b00};
	end

	// Fetch only hands over decodable words on the correct path.
	knownOpcode: assert property (@(posedge clk) disable iff (rst_i)
		fetchDec.valid && !flushE_i |-> knownOp)
		else $error("Valid instruction with unknown opcode at pc %h", fetchDec.pc);

endmodule

/* logic/executeStage.sv */
`timescale 1ns/100ps

module executeStage (
	input logic clk,
	input logic rst_i,
	input pipePkg::fwdSel_e fwdA_i,
	input pipePkg::fwdSel_e fwdB_i,
	decExIfc.dst decEx,
	exMemIfc.src exMem,
	wbIfc.dst wb,
	output logic memReadE_o,
	output pipePkg::regAddr_t destRegE_o,
	output logic redirect_o,
	output pipePkg::word_t redirectPc_o
);
	import pipePkg::*;

	word_t srcA;
	word_t srcB;
	word_t aluB;
	word_t aluResult;
	word_t branchTarget;
	logic branchTaken;

	function automatic word_t pickOperand(fwdSel_e sel, word_t regVal);
		case (sel)
			fromMem: return exMem.aluResult;
			fromWb: return wb.wbData;
			default: return regVal;
		endcase
	endfunction

	assign srcA = pickOperand(fwdA_i, decEx.rsVal);
	assign srcB = pickOperand(fwdB_i, decEx.rtVal);
	assign aluB = decEx.ctrl.useImm ? decEx.imm : srcB;

	always_comb begin
		case (decEx.ctrl.aluOp)
			aluAdd: aluResult = srcA + aluB;
			aluSub: aluResult = srcA - aluB;
			aluAnd: aluResult = srcA & aluB;
			aluOr: aluResult = srcA | aluB;
			aluSlt: aluResult = {31'b0, $signed(srcA) < $signed(aluB)};
			default: aluResult = aluB;
		endcase
	end

	// No delay slot, so the branch target is relative to the branch's own pc+4.
	assign branchTarget = decEx.pc + 32'd4 + {decEx.imm[29:0], 2'b00};
	assign branchTaken = decEx.ctrl.isBranch && srcA == srcB;
	assign redirect_o = decEx.valid && (branchTaken || decEx.ctrl.isJump);
	assign redirectPc_o = decEx.ctrl.isJump ? decEx.jumpTarget : branchTarget;

	assign memReadE_o = decEx.valid && decEx.ctrl.memRead;
	assign destRegE_o = decEx.destReg;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			exMem.valid <= 1'b0;
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
		end else begin
			exMem.valid <= decEx.valid;
			exMem.regWrite <= decEx.valid && decEx.ctrl.regWrite;
			exMem.memRead <= decEx.valid && decEx.ctrl.memRead;
			exMem.memWrite <= decEx.valid && decEx.ctrl.memWrite;
		end
	end

	always_ff @(posedge clk) begin
		exMem.pc <= decEx.pc;
		exMem.destReg <= decEx.destReg;
		exMem.aluResult <= aluResult;
		exMem.storeData <= srcB;
	end

	// The slot behind a redirecting instruction has been flushed by the hazard unit.
	flushAfterRedirect: assert property (@(posedge clk) disable iff (rst_i)
		redirect_o |=> !decEx.valid)
		else $error("Entry behind a redirect was not flushed, pc %h", decEx.pc);

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/100ps

module fetchStage #(
	parameter pipePkg::word_t resetPc = '0
) (
	input logic clk,
	input logic rst_i,
	input logic stallF_i,
	input logic stallD_i,
	input logic flushD_i,
	input logic redirect_i,
	input pipePkg::word_t redirectPc_i,
	output pipePkg::word_t instAddr_o,
	input pipePkg::word_t instRdata_i,
	fetchDecIfc.src fetchDec
);
	import pipePkg::*;

	word_t pc;

	assign instAddr_o = pc;

	// A redirect from execute wins over a load-use hold.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc <= resetPc;
		end else if (redirect_i) begin
			pc <= redirectPc_i;
		end else if (!stallF_i) begin
			pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			fetchDec.valid <= 1'b0;
		end else if (flushD_i) begin
			fetchDec.valid <= 1'b0;
		end else if (!stallD_i) begin
			fetchDec.valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD_i) begin
			fetchDec.pc <= pc;
			fetchDec.instr <= instRdata_i;
		end
	end

endmodule

/* logic/hazardUnit.sv */
`timescale 1ns/100ps

module hazardUnit (
	input logic clk,
	input logic rst_i,
	input pipePkg::regAddr_t rsD_i,
	input pipePkg::regAddr_t rtD_i,
	input logic memReadE_i,
	input pipePkg::regAddr_t destRegE_i,
	input logic redirect_i,
	decExIfc.dst decEx,
	exMemIfc.dst exMem,
	wbIfc.dst wb,
	output logic stallF_o,
	output logic stallD_o,
	output logic flushD_o,
	output logic flushE_o,
	output pipePkg::fwdSel_e fwdA_o,
	output pipePkg::fwdSel_e fwdB_o
);
	import pipePkg::*;

	logic loadUse;

	// The younger producer in memory wins over the one in writeback.
	function automatic fwdSel_e pickSource(regAddr_t r);
		if (r == '0) begin
			return fromRegs;
		end else if (exMem.valid && exMem.regWrite && exMem.destReg == r) begin
			return fromMem;
		end else if (wb.valid && wb.regWrite && wb.destReg == r) begin
			return fromWb;
		end
		return fromRegs;
	endfunction

	// A load's data only exists after memory and so reaches execute one cycle too late.
	assign loadUse = memReadE_i && destRegE_i != '0
		&& (destRegE_i == rsD_i || destRegE_i == rtD_i);

	assign stallF_o = loadUse;
	assign stallD_o = loadUse;
	assign flushD_o = redirect_i;
	assign flushE_o = loadUse || redirect_i;

	assign fwdA_o = pickSource(decEx.rs);
	assign fwdB_o = pickSource(decEx.rt);

	stallVsFlush: assert property (@(posedge clk) disable iff (rst_i)
		!(stallD_o && flushD_o))
		else $error("Load-use stall and redirect flush hit decode together");

endmodule

/* logic/memStage.sv */
`timescale 1ns/100ps

module memStage (
	input logic clk,
	input logic rst_i,
	exMemIfc.dst exMem,
	wbIfc.src wb,
	output pipePkg::word_t dataAddr_o,
	output logic dataWe_o,
	output pipePkg::word_t dataWdata_o,
	input pipePkg::word_t dataRdata_i
);
	import pipePkg::*;

	word_t memResult;

	assign dataAddr_o = exMem.aluResult;
	assign dataWe_o = exMem.valid && exMem.memWrite;
	assign dataWdata_o = exMem.storeData;

	assign memResult = exMem.memRead ? dataRdata_i : exMem.aluResult;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wb.valid <= 1'b0;
			wb.regWrite <= 1'b0;
		end else begin
			wb.valid <= exMem.valid;
			wb.regWrite <= exMem.valid && exMem.regWrite;
		end
	end

	always_ff @(posedge clk) begin
		wb.pc <= exMem.pc;
		wb.destReg <= exMem.destReg;
		wb.wbData <= memResult;
	end

	// Only word accesses exist, so the low address bits must be clear.
	wordAligned: assert property (@(posedge clk) disable iff (rst_i)
		exMem.valid && (exMem.memRead || exMem.memWrite) |-> dataAddr_o[1:0] == 2'b00)
		else $error("Misaligned data access to %h from pc %h", dataAddr_o, exMem.pc);

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/100ps

module mipsCore #(
	parameter pipePkg::word_t resetPc = '0
) (
	input logic clk,
	input logic rst_i,
	output pipePkg::word_t instAddr_o,
	input pipePkg::word_t instRdata_i,
	output pipePkg::word_t dataAddr_o,
	output logic dataWe_o,
	output pipePkg::word_t dataWdata_o,
	input pipePkg::word_t dataRdata_i,
	output pipePkg::word_t wbPc_o,
	output logic wbRegWe_o,
	output pipePkg::regAddr_t wbRegNum_o,
	output pipePkg::word_t wbRegData_o
);
	import pipePkg::*;

	regAddr_t rsD;
	regAddr_t rtD;
	logic memReadE;
	regAddr_t destRegE;
	logic redirect;
	word_t redirectPc;
	logic stallF;
	logic stallD;
	logic flushD;
	logic flushE;
	fwdSel_e fwdA;
	fwdSel_e fwdB;

	fetchDecIfc fetchDecBus ();
	decExIfc decExBus ();
	exMemIfc exMemBus ();
	wbIfc wbBus ();

	fetchStage #(.resetPc(resetPc)) fetch_i (
		.clk(clk), .rst_i(rst_i),
		.stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD),
		.redirect_i(redirect), .redirectPc_i(redirectPc),
		.instAddr_o(instAddr_o), .instRdata_i(instRdata_i),
		.fetchDec(fetchDecBus.src)
	);

	decodeStage decode_i (
		.clk(clk), .rst_i(rst_i), .flushE_i(flushE), .stallD_i(stallD),
		.fetchDec(fetchDecBus.dst), .wb(wbBus.dst), .decEx(decExBus.src),
		.rsD_o(rsD), .rtD_o(rtD)
	);

	executeStage execute_i (
		.clk(clk), .rst_i(rst_i), .fwdA_i(fwdA), .fwdB_i(fwdB),
		.decEx(decExBus.dst), .exMem(exMemBus.src), .wb(wbBus.dst),
		.memReadE_o(memReadE), .destRegE_o(destRegE),
		.redirect_o(redirect), .redirectPc_o(redirectPc)
	);

	memStage mem_i (
		.clk(clk), .rst_i(rst_i), .exMem(exMemBus.dst), .wb(wbBus.src),
		.dataAddr_o(dataAddr_o), .dataWe_o(dataWe_o),
		.dataWdata_o(dataWdata_o), .dataRdata_i(dataRdata_i)
	);

	hazardUnit hazard_i (
		.clk(clk), .rst_i(rst_i), .rsD_i(rsD), .rtD_i(rtD),
		.memReadE_i(memReadE), .destRegE_i(destRegE), .redirect_i(redirect),
		.decEx(decExBus.dst), .exMem(exMemBus.dst), .wb(wbBus.dst),
		.stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
		.fwdA_o(fwdA), .fwdB_o(fwdB)
	);

	// Writes to register 0 retire silently.
	assign wbPc_o = wbBus.pc;
	assign wbRegWe_o = wbBus.valid && wbBus.regWrite && wbBus.destReg != '0;
	assign wbRegNum_o = wbBus.destReg;
	assign wbRegData_o = wbBus.wbData;

endmodule

/* logic/pipeIfc.sv */
`timescale 1ns/100ps

interface fetchDecIfc;
	import pipePkg::*;
	logic valid;
	word_t pc;
	word_t instr;
	modport src (output valid, pc, instr);
	modport dst (input valid, pc, instr);
endinterface

interface decExIfc;
	import pipePkg::*;
	logic valid;
	word_t pc;
	ctrl_t ctrl;
	word_t rsVal;
	word_t rtVal;
	word_t imm;
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t destReg;
	word_t jumpTarget;
	modport src (output valid, pc, ctrl, rsVal, rtVal, imm, rs, rt, destReg, jumpTarget);
	modport dst (input valid, pc, ctrl, rsVal, rtVal, imm, rs, rt, destReg, jumpTarget);
endinterface

interface exMemIfc;
	import pipePkg::*;
	logic valid;
	word_t pc;
	logic regWrite;
	logic memRead;
	logic memWrite;
	regAddr_t destReg;
	word_t aluResult;
	word_t storeData;
	modport src (output valid, pc, regWrite, memRead, memWrite, destReg, aluResult, storeData);
	modport dst (input valid, pc, regWrite, memRead, memWrite, destReg, aluResult, storeData);
endinterface

interface wbIfc;
	import pipePkg::*;
	logic valid;
	word_t pc;
	logic regWrite;
	regAddr_t destReg;
	word_t wbData;
	modport src (output valid, pc, regWrite, destReg, wbData);
	modport dst (input valid, pc, regWrite, destReg, wbData);
endinterface

/* logic/pipePkg.sv */
package pipePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;

	// Primary opcode field in instr[31:26].
	typedef enum logic [5:0] {
		rType = 6'h00,
		j     = 6'h02,
		beq   = 6'h04,
		addiu = 6'h09,
		ori   = 6'h0d,
		lw    = 6'h23,
		sw    = 6'h2b
	} opcode_e;

	// Function field of R-type instructions in instr[5:0].
	typedef enum logic [5:0] {
		addu  = 6'h21,
		subu  = 6'h23,
		andOp = 6'h24,
		orOp  = 6'h25,
		slt   = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluPassB
	} aluOp_e;

	typedef enum logic [1:0] {
		fromRegs,
		fromMem,
		fromWb
	} fwdSel_e;

	typedef struct packed {
		aluOp_e aluOp;
		logic useImm;
		logic zeroExtend;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic isBranch;
		logic isJump;
	} ctrl_t;

endpackage

/* mipsLite.f */
logic/pipePkg.sv
logic/pipeIfc.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memStage.sv
logic/hazardUnit.sv
logic/mipsCore.sv
tb/progModel.sv
tb/coreTb.sv

/* run.sh */
#!/bin/sh
# Builds the mipsLite testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module coreTb -f mipsLite.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/VcoreTb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0

/* tb/coreTb.sv */
`timescale 1ns/100ps

module coreTb;
	import pipePkg::*;

	localparam word_t resetPc = 32'h0000_0080;
	localparam int randomCount = 48;

	logic clk;
	logic rst_i;
	logic rstQ;
	logic built;
	integer seed;
	word_t instAddr;
	word_t instRdata;
	word_t dataAddr;
	logic dataWe;
	word_t dataWdata;
	word_t dataRdata;
	word_t wbPc;
	logic wbRegWe;
	regAddr_t wbRegNum;
	word_t wbRegData;
	logic writesLeft;
	logic storesLeft;
	word_t expPc;
	regAddr_t expNum;
	word_t expData;
	word_t expStAddr;
	word_t expStData;

	mipsCore #(.resetPc(resetPc)) mipsCore_i (
		.clk(clk), .rst_i(rst_i),
		.instAddr_o(instAddr), .instRdata_i(instRdata),
		.dataAddr_o(dataAddr), .dataWe_o(dataWe),
		.dataWdata_o(dataWdata), .dataRdata_i(dataRdata),
		.wbPc_o(wbPc), .wbRegWe_o(wbRegWe),
		.wbRegNum_o(wbRegNum), .wbRegData_o(wbRegData)
	);

	progModel #(.resetPc(resetPc)) model_i (
		.clk(clk), .instAddr_i(instAddr), .instRdata_o(instRdata),
		.dataAddr_i(dataAddr), .dataWe_i(dataWe), .dataWdata_i(dataWdata),
		.dataRdata_o(dataRdata), .wbRegWe_i(wbRegWe),
		.writesLeft_o(writesLeft), .expPc_o(expPc), .expNum_o(expNum),
		.expData_o(expData), .storesLeft_o(storesLeft),
		.expStAddr_o(expStAddr), .expStData_o(expStData)
	);

	function automatic word_t rInstr(logic [5:0] fn, regAddr_t rd, regAddr_t rs, regAddr_t rt);
		return {6'h00, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic word_t iInstr(logic [5:0] op, regAddr_t rt, regAddr_t rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jInstr(word_t target);
		return {6'h02, target[27:2]};
	endfunction

	task automatic stopWithFailure(string what);
		$display("%s", what);
		$display("Test failures found");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic buildProgram();
		word_t pc;
		int r;
		logic [5:0] fn;
		model_i.resetMemories();
		// Back-to-back dependences forward from memory and writeback.
		model_i.emit(iInstr(ori, 5'd1, 5'd0, 16'h1234));
		model_i.emit(iInstr(addiu, 5'd2, 5'd0, 16'hfffb));
		model_i.emit(rInstr(addu, 5'd3, 5'd1, 5'd2));
		model_i.emit(rInstr(subu, 5'd4, 5'd3, 5'd1));
		model_i.emit(rInstr(slt, 5'd5, 5'd2, 5'd1));
		model_i.emit(rInstr(andOp, 5'd6, 5'd3, 5'd1));
		model_i.emit(rInstr(orOp, 5'd7, 5'd4, 5'd5));
		// Stores, loads and load-use stalls.
		model_i.emit(iInstr(addiu, 5'd8, 5'd0, 16'h0040));
		model_i.emit(iInstr(sw, 5'd3, 5'd8, 16'h0000));
		model_i.emit(iInstr(sw, 5'd7, 5'd8, 16'h0004));
		model_i.emit(iInstr(lw, 5'd9, 5'd8, 16'h0000));
		model_i.emit(rInstr(addu, 5'd10, 5'd9, 5'd9));
		model_i.emit(iInstr(lw, 5'd11, 5'd8, 16'h0004));
		model_i.emit(iInstr(lw, 5'd12, 5'd8, 16'h0008));
		model_i.emit(rInstr(subu, 5'd13, 5'd12, 5'd11));
		model_i.emit(iInstr(sw, 5'd13, 5'd8, 16'h0008));
		model_i.emit(iInstr(lw, 5'd14, 5'd8, 16'h0008));
		model_i.emit(rInstr(orOp, 5'd15, 5'd14, 5'd0));
		// Register 0 must stay zero.
		model_i.emit(iInstr(addiu, 5'd0, 5'd0, 16'h0007));
		model_i.emit(rInstr(addu, 5'd16, 5'd0, 5'd0));
		// Not-taken and taken branches, then a jump over two slots.
		model_i.emit(iInstr(beq, 5'd2, 5'd1, 16'h0001));
		model_i.emit(iInstr(addiu, 5'd17, 5'd0, 16'h0001));
		model_i.emit(iInstr(beq, 5'd3, 5'd3, 16'h0002));
		model_i.emit(iInstr(addiu, 5'd18, 5'd0, 16'h0bad));
		model_i.emit(iInstr(sw, 5'd18, 5'd8, 16'h000c));
		model_i.emit(iInstr(addiu, 5'd19, 5'd0, 16'h0002));
		pc = resetPc + 32'(4 * model_i.progLen);
		model_i.emit(jInstr(pc + 32'd12));
		model_i.emit(iInstr(addiu, 5'd20, 5'd0, 16'h0bad));
		model_i.emit(iInstr(sw, 5'd20, 5'd8, 16'h0010));
		model_i.emit(iInstr(addiu, 5'd22, 5'd0, 16'h0003));
		// A branch that waits on a load.
		model_i.emit(iInstr(lw, 5'd23, 5'd8, 16'h0000));
		model_i.emit(iInstr(beq, 5'd3, 5'd23, 16'h0001));
		model_i.emit(iInstr(addiu, 5'd24, 5'd0, 16'h0bad));
		model_i.emit(iInstr(addiu, 5'd25, 5'd0, 16'h0004));
		for (int n = 0; n < randomCount; n++) begin
			r = $random(seed);
			case (r[2:0])
				3'd0: fn = addu;
				3'd1: fn = subu;
				3'd2: fn = andOp;
				3'd3: fn = orOp;
				default: fn = slt;
			endcase
			if (r[2:0] == 3'd5) begin
				model_i.emit(iInstr(addiu, {2'b0, r[5:3]}, {2'b0, r[8:6]}, r[27:12]));
			end else if (r[2:0] >= 3'd6) begin
				model_i.emit(iInstr(ori, {2'b0, r[5:3]}, {2'b0, r[8:6]}, r[27:12]));
			end else begin
				model_i.emit(rInstr(fn, {2'b0, r[5:3]}, {2'b0, r[8:6]}, {2'b0, r[11:9]}));
			end
		end
		pc = resetPc + 32'(4 * model_i.progLen);
		model_i.emit(jInstr(pc));
	endtask

	initial begin
		clk = 1'b0;
	end

	always #50 clk = ~clk;

	initial begin
		rstQ = 1'b0;
	end

	always @(posedge clk) begin
		rstQ <= rst_i;
	end

	initial begin
		seed = 32'h5e19;
		built = 1'b0;
		rst_i = 1'b1;
		buildProgram();
		model_i.runReference();
		built = 1'b1;
		repeat (16) @(posedge clk);
		#1 rst_i = 1'b0;
		wait (!writesLeft && !storesLeft);
		// A few more cycles catch any write or store beyond the expected ones.
		repeat (10) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

	initial begin
		wait (built);
		repeat (16 + 10 * model_i.progLen + 50) @(posedge clk);
		stopWithFailure("Timeout: the program never finished");
	end

	writeMatch: assert property (@(posedge clk) disable iff (rst_i)
		wbRegWe |-> writesLeft && wbPc == expPc && wbRegNum == expNum && wbRegData == expData)
		else stopWithFailure($sformatf(
			"MISMATCH %0t: write pc %h r%0d %h, expected pc %h r%0d %h", $time,
			$sampled(wbPc), $sampled(wbRegNum), $sampled(wbRegData),
			$sampled(expPc), $sampled(expNum), $sampled(expData)));

	storeMatch: assert property (@(posedge clk) disable iff (rst_i)
		dataWe |-> storesLeft && dataAddr == expStAddr && dataWdata == expStData)
		else stopWithFailure($sformatf(
			"MISMATCH %0t: store %h to %h, expected %h to %h", $time,
			$sampled(dataWdata), $sampled(dataAddr),
			$sampled(expStData), $sampled(expStAddr)));

	zeroRegQuiet: assert property (@(posedge clk) disable iff (rst_i)
		wbRegWe |-> wbRegNum != '0)
		else stopWithFailure($sformatf("MISMATCH %0t: write enable for register 0", $time));

	// Covers the reset cycles and the first cycle after reset drops.
	resetQuiet: assert property (@(posedge clk)
		rstQ |-> !wbRegWe && !dataWe)
		else stopWithFailure($sformatf("MISMATCH %0t: write enable during reset", $time));

	firstFetch: assert property (@(posedge clk)
		rstQ && !rst_i |-> instAddr == resetPc)
		else stopWithFailure($sformatf("MISMATCH %0t: first fetch at %h, expected %h",
			$time, $sampled(instAddr), resetPc));

endmodule

/* tb/progModel.sv */
`timescale 1ns/100ps

module progModel #(
	parameter pipePkg::word_t resetPc = '0
) (
	input logic clk,
	input pipePkg::word_t instAddr_i,
	output pipePkg::word_t instRdata_o,
	input pipePkg::word_t dataAddr_i,
	input logic dataWe_i,
	input pipePkg::word_t dataWdata_i,
	output pipePkg::word_t dataRdata_o,
	input logic wbRegWe_i,
	output logic writesLeft_o,
	output pipePkg::word_t expPc_o,
	output pipePkg::regAddr_t expNum_o,
	output pipePkg::word_t expData_o,
	output logic storesLeft_o,
	output pipePkg::word_t expStAddr_o,
	output pipePkg::word_t expStData_o
);
	import pipePkg::*;

	word_t imem [256];
	word_t dmem [256];
	word_t refRegs [32];
	word_t refMem [256];
	word_t pcQ [$];
	regAddr_t numQ [$];
	word_t dataQ [$];
	word_t stAddrQ [$];
	word_t stDataQ [$];
	int progLen = 0;
	int wrTotal = 0;
	int stTotal = 0;
	int wrIdx = 0;
	int stIdx = 0;

	// Initial data memory contents differ for every word address.
	function automatic word_t fillWord(int idx);
		return (idx * 32'h9e3779b1) ^ 32'hd00d0000;
	endfunction

	task automatic resetMemories();
		for (int i = 0; i < 256; i++) begin
			imem[i] = '0;
			dmem[i] = fillWord(i);
		end
		progLen = 0;
	endtask

	task automatic emit(word_t instr);
		imem[resetPc[9:2] + progLen] = instr;
		progLen++;
	endtask

	task automatic retire(word_t pc, regAddr_t r, word_t v);
		if (r != '0) begin
			refRegs[r] = v;
			pcQ.push_back(pc);
			numQ.push_back(r);
			dataQ.push_back(v);
		end
	endtask

	// Executes the program in order until it reaches the jump to itself.
	task automatic runReference();
		word_t pc;
		word_t instr;
		word_t a;
		word_t b;
		word_t sImm;
		word_t addr;
		word_t nextPc;
		word_t jumpPc;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			refMem[i] = fillWord(i);
		end
		pc = resetPc;
		for (int step = 0; step < 4096; step++) begin
			instr = imem[pc[9:2]];
			rs = instr[25:21];
			rt = instr[20:16];
			rd = instr[15:11];
			a = refRegs[rs];
			b = refRegs[rt];
			sImm = {{16{instr[15]}}, instr[15:0]};
			nextPc = pc + 32'd4;
			case (instr[31:26])
				6'h00: begin
					case (instr[5:0])
						6'h21: retire(pc, rd, a + b);
						6'h23: retire(pc, rd, a - b);
						6'h24: retire(pc, rd, a & b);
						6'h25: retire(pc, rd, a | b);
						6'h2a: retire(pc, rd, {31'b0, $signed(a) < $signed(b)});
						default: ;
					endcase
				end
				6'h09: retire(pc, rt, a + sImm);
				6'h0d: retire(pc, rt, a | {16'b0, instr[15:0]});
				6'h23: begin
					addr = a + sImm;
					retire(pc, rt, refMem[addr[9:2]]);
				end
				6'h2b: begin
					addr = a + sImm;
					refMem[addr[9:2]] = b;
					stAddrQ.push_back(addr);
					stDataQ.push_back(b);
				end
				6'h04: begin
					if (a == b) begin
						nextPc = pc + 32'd4 + {sImm[29:0], 2'b00};
					end
				end
				6'h02: begin
					jumpPc = {nextPc[31:28], instr[25:0], 2'b00};
					if (jumpPc == pc) begin
						break;
					end
					nextPc = jumpPc;
				end
				default: ;
			endcase
			pc = nextPc;
		end
		wrTotal = pcQ.size();
		stTotal = stAddrQ.size();
	endtask

	assign instRdata_o = imem[instAddr_i[9:2]];
	assign dataRdata_o = dmem[dataAddr_i[9:2]];

	always @(posedge clk) begin
		if (dataWe_i) begin
			dmem[dataAddr_i[9:2]] <= dataWdata_i;
		end
	end

	// Each retirement or store seen from the core moves on to the next expected one.
	always @(posedge clk) begin
		if (wbRegWe_i) begin
			wrIdx <= wrIdx + 1;
		end
		if (dataWe_i) begin
			stIdx <= stIdx + 1;
		end
	end

	always_comb begin
		writesLeft_o = wrIdx < wrTotal;
		storesLeft_o = stIdx < stTotal;
		expPc_o = writesLeft_o ? pcQ[wrIdx] : '0;
		expNum_o = writesLeft_o ? numQ[wrIdx] : '0;
		expData_o = writesLeft_o ? dataQ[wrIdx] : '0;
		expStAddr_o = storesLeft_o ? stAddrQ[stIdx] : '0;
		expStData_o = storesLeft_o ? stDataQ[stIdx] : '0;
	end

endmodule
